/* flist.f */
+incdir+include
source/bru_pkg.sv
source/stream_register.sv
source/warp_regfile.sv
source/operand_collector.sv
source/branch_unit.sv
source/result_collector.sv
source/branch_subsystem.sv
tb/tb_branch_subsystem.sv

/* Makefile */
# Verilator build and run for the branch subsystem testbench

SIM := obj_dir/Vtb_branch_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f flist.f --top-module tb_branch_subsystem

run: compile
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* tb/tb_branch_subsystem.sv */
/*
 * Branch subsystem testbench
 * Random loads and branches checked against a register model and expected queues
 */

`timescale 1ns/100ps

`include "bru_macros.svh"

module tb_branch_subsystem;

    import bru_pkg::*;

    typedef logic [127:0] cmp_t;

    localparam int TIMEOUT = 300;

    logic            clk_i = 1'b0;
    logic            arst_n_i;
    logic            issue_valid_i;
    issue_req_t      issue_req_i;
    logic            issue_ready_o;
    logic            load_valid_i;
    rf_write_t       load_i;
    logic            load_ready_o;
    logic            cpl_valid_o;
    bru_result_t     cpl_o;
    logic            cpl_ready_i;
    fetch_redirect_t redirect_o;

    // Reference model, register array plus expected streams in issue order
    warp_data_t      model_rf [`BRU_NUM_WARPS][`BRU_NUM_REGS];
    fetch_redirect_t exp_redirects [$];
    bru_result_t     exp_cpls [$];
    int              issue_cycles [$];

    int   cycle_cnt;
    int   issue_cnt;
    int   sent_cnt;
    int   redirect_cnt;
    int   cpl_cnt;
    logic stall_en;
    logic latency_en;

    always #50 clk_i = ~clk_i;

    branch_subsystem i_branch_subsystem (
        .clk_i         ( clk_i         ),
        .arst_n_i      ( arst_n_i      ),
        .issue_valid_i ( issue_valid_i ),
        .issue_req_i   ( issue_req_i   ),
        .issue_ready_o ( issue_ready_o ),
        .load_valid_i  ( load_valid_i  ),
        .load_i        ( load_i        ),
        .load_ready_o  ( load_ready_o  ),
        .cpl_valid_o   ( cpl_valid_o   ),
        .cpl_o         ( cpl_o         ),
        .cpl_ready_i   ( cpl_ready_i   ),
        .redirect_o    ( redirect_o    )
    );

    // ##############################
    // Reporting
    // ##############################

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, cmp_t actual, cmp_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic report_stuck(string what);
        $display("Timeout: %s", what);
        abort_run();
    endtask

    // ##############################
    // Model
    // ##############################

    // Taken lanes per branch kind, tested on operand 1
    function automatic act_mask_t lane_condition(bru_subtype_e kind, warp_data_t op1);
        act_mask_t c;
        for (int l = 0; l < `BRU_WARP_WIDTH; l++) begin
            if (kind == BRU_BNZ) begin
                c[l] = |op1[l];
            end else begin
                c[l] = ~|op1[l];
            end
        end
        return c;
    endfunction

    function automatic fetch_redirect_t predict_redirect(issue_req_t r, warp_data_t op0,
                                                         warp_data_t op1);
        fetch_redirect_t x;
        logic signed [`BRU_OFFSET_WIDTH-1:0] offset;
        offset  = op0[0][`BRU_OFFSET_WIDTH-1:0];
        x.valid = 1'b1;
        x.wid   = r.iid[$bits(wid_t)-1:0];
        x.mask  = r.act_mask & lane_condition(r.subtype, op1);
        // Signed offset, then one more
        x.pc    = r.pc + pc_t'(offset) + pc_t'(1);
        return x;
    endfunction

    function automatic bru_result_t predict_result(issue_req_t r, warp_data_t op1);
        bru_result_t x;
        act_mask_t   c;
        c          = lane_condition(r.subtype, op1);
        x.iid      = r.iid;
        x.dst      = r.dst;
        x.act_mask = r.act_mask;
        for (int l = 0; l < `BRU_WARP_WIDTH; l++) begin
            x.data[l] = `BRU_REG_WIDTH'(c[l]);
        end
        return x;
    endfunction

    // Lane-masked update of the model array
    function automatic void apply_write(rf_write_t w);
        for (int l = 0; l < `BRU_WARP_WIDTH; l++) begin
            if (w.mask[l]) begin
                model_rf[w.wid][w.idx][l] = w.data[l];
            end
        end
    endfunction

    // ##############################
    // Stimulus generators
    // ##############################

    function automatic warp_data_t random_warp_data();
        warp_data_t d;
        for (int l = 0; l < `BRU_WARP_WIDTH; l++) begin
            // About a third of lanes zero, so both kinds take and fall through
            if ($urandom_range(2, 0) == 0) begin
                d[l] = '0;
            end else begin
                d[l] = $urandom();
            end
        end
        return d;
    endfunction

    function automatic issue_req_t make_branch(int src_lo, int src_hi, int dst_lo, int dst_hi);
        issue_req_t r;
        r.iid      = iid_t'($urandom());
        r.pc       = pc_t'($urandom());
        r.subtype  = ($urandom_range(1, 0) == 0) ? BRU_BNZ : BRU_BEZ;
        r.dst      = reg_idx_t'($urandom_range(dst_hi, dst_lo));
        r.src0     = reg_idx_t'($urandom_range(src_hi, src_lo));
        r.src1     = reg_idx_t'($urandom_range(src_hi, src_lo));
        r.act_mask = act_mask_t'($urandom_range((1 << `BRU_WARP_WIDTH) - 1, 1));
        return r;
    endfunction

    // Partial load into one of the source registers
    function automatic rf_write_t make_load();
        rf_write_t w;
        w.wid  = wid_t'($urandom());
        w.idx  = reg_idx_t'($urandom_range(7, 0));
        w.mask = act_mask_t'($urandom_range((1 << `BRU_WARP_WIDTH) - 1, 1));
        w.data = random_warp_data();
        return w;
    endfunction

    // ##############################
    // Drivers
    // ##############################

    task automatic issue_branch(issue_req_t r);
        int waited;
        waited = 0;
        @(negedge clk_i);
        issue_valid_i = 1'b1;
        issue_req_i   = r;
        @(posedge clk_i);
        while (!issue_ready_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_stuck("issue_ready_o stayed low with an issue pending");
            end
            @(posedge clk_i);
        end
        sent_cnt++;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
    endtask

    task automatic load_register(rf_write_t w);
        int waited;
        waited = 0;
        @(negedge clk_i);
        load_valid_i = 1'b1;
        load_i       = w;
        @(posedge clk_i);
        while (!load_ready_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_stuck("load_ready_o stayed low with a load pending");
            end
            @(posedge clk_i);
        end
        @(negedge clk_i);
        load_valid_i = 1'b0;
    endtask

    // All outstanding redirects and completions seen
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_redirects.size() != 0 || exp_cpls.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_stuck("outstanding branches never drained");
            end
            @(posedge clk_i);
        end
    endtask

    // Completion back-pressure, mostly low while stalling
    initial begin : ready_driver
        cpl_ready_i = 1'b1;
        forever begin
            @(negedge clk_i);
            if (stall_en) begin
                cpl_ready_i = ($urandom_range(2, 0) == 0);
            end else begin
                cpl_ready_i = 1'b1;
            end
        end
    end

    // ##############################
    // Monitor
    // ##############################

    always @(posedge clk_i) begin : monitor
        wid_t            w;
        warp_data_t      op0;
        warp_data_t      op1;
        fetch_redirect_t exp_r;
        bru_result_t     exp_c;
        rf_write_t       wb;
        int              lat;
        if (arst_n_i) begin
            cycle_cnt++;
            // Writeback owns the write port in its cycle, loads wait
            check_value("load_ready_o", cmp_t'(load_ready_o),
                        cmp_t'(!(cpl_valid_o && cpl_ready_i)));
            // Without back-pressure the collector never fills
            if (latency_en) begin
                check_value("issue_ready_o", cmp_t'(issue_ready_o), cmp_t'(1));
            end
            // Operands come from the array before this edge's writes
            if (issue_valid_i && issue_ready_o) begin
                w   = issue_req_i.iid[$bits(wid_t)-1:0];
                op0 = model_rf[w][issue_req_i.src0];
                op1 = model_rf[w][issue_req_i.src1];
                exp_redirects.push_back(predict_redirect(issue_req_i, op0, op1));
                exp_cpls.push_back(predict_result(issue_req_i, op1));
                issue_cycles.push_back(cycle_cnt);
                issue_cnt++;
            end
            if (redirect_o.valid) begin
                if (exp_redirects.size() == 0) begin
                    $display("Redirect pulse seen with no branch outstanding");
                    abort_run();
                end
                exp_r = exp_redirects.pop_front();
                lat   = cycle_cnt - issue_cycles.pop_front();
                check_value("redirect_o.wid", cmp_t'(redirect_o.wid), cmp_t'(exp_r.wid));
                check_value("redirect_o.mask", cmp_t'(redirect_o.mask), cmp_t'(exp_r.mask));
                check_value("redirect_o.pc", cmp_t'(redirect_o.pc), cmp_t'(exp_r.pc));
                if (latency_en) begin
                    check_value("redirect latency", cmp_t'(lat), cmp_t'(2));
                end
                redirect_cnt++;
            end
            if (cpl_valid_o && cpl_ready_i) begin
                if (exp_cpls.size() == 0) begin
                    $display("Completion seen with no branch outstanding");
                    abort_run();
                end
                exp_c = exp_cpls.pop_front();
                check_value("cpl_o.iid", cmp_t'(cpl_o.iid), cmp_t'(exp_c.iid));
                check_value("cpl_o.dst", cmp_t'(cpl_o.dst), cmp_t'(exp_c.dst));
                check_value("cpl_o.act_mask", cmp_t'(cpl_o.act_mask), cmp_t'(exp_c.act_mask));
                check_value("cpl_o.data", cmp_t'(cpl_o.data), cmp_t'(exp_c.data));
                // Writeback lands in the issuing warp on active lanes only
                wb.wid  = exp_c.iid[$bits(wid_t)-1:0];
                wb.idx  = exp_c.dst;
                wb.mask = exp_c.act_mask;
                wb.data = exp_c.data;
                apply_write(wb);
                cpl_cnt++;
            end
            // Load only counts when the file accepts it
            if (load_valid_i && load_ready_o) begin
                apply_write(load_i);
            end
        end
    end

    // ##############################
    // Sequence
    // ##############################

    initial begin : main
        rf_write_t w;
        void'($urandom(40));
        arst_n_i      = 1'b0;
        issue_valid_i = 1'b0;
        issue_req_i   = '0;
        load_valid_i  = 1'b0;
        load_i        = '0;
        stall_en      = 1'b0;
        latency_en    = 1'b1;
        cycle_cnt     = 0;
        issue_cnt     = 0;
        sent_cnt      = 0;
        redirect_cnt  = 0;
        cpl_cnt       = 0;
        for (int wi = 0; wi < `BRU_NUM_WARPS; wi++) begin
            for (int ri = 0; ri < `BRU_NUM_REGS; ri++) begin
                model_rf[wi][ri] = '0;
            end
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        @(posedge clk_i);
        check_value("redirect_o.valid", cmp_t'(redirect_o.valid), cmp_t'(0));
        check_value("cpl_valid_o", cmp_t'(cpl_valid_o), cmp_t'(0));

        // Zeroed file, BNZ never taken and BEZ taken on every active lane
        repeat (8) issue_branch(make_branch(0, 7, 8, 15));
        wait_drain();

        // Fill sources 0 to 7 of every warp
        for (int wi = 0; wi < `BRU_NUM_WARPS; wi++) begin
            for (int ri = 0; ri < 8; ri++) begin
                w.wid  = wid_t'(wi);
                w.idx  = reg_idx_t'(ri);
                w.mask = '1;
                w.data = random_warp_data();
                load_register(w);
            end
        end

        // Branches writing 8 to 15
        repeat (40) issue_branch(make_branch(0, 7, 8, 15));
        wait_drain();

        // Read back the masked writebacks
        repeat (30) issue_branch(make_branch(8, 15, 0, 7));
        wait_drain();

        // Completion back-pressure fills the pipe
        stall_en   = 1'b1;
        latency_en = 1'b0;
        repeat (40) issue_branch(make_branch(0, 7, 8, 15));
        stall_en = 1'b0;
        wait_drain();
        latency_en = 1'b1;

        // Loads racing writebacks for the write port
        fork
            repeat (40) load_register(make_load());
            repeat (40) issue_branch(make_branch(0, 7, 8, 15));
        join
        wait_drain();

        check_value("issue count", cmp_t'(issue_cnt), cmp_t'(sent_cnt));
        check_value("redirect count", cmp_t'(redirect_cnt), cmp_t'(sent_cnt));
        check_value("completion count", cmp_t'(cpl_cnt), cmp_t'(sent_cnt));
        $display("Verification passed");
        $finish;
    end

endmodule

/* source/branch_subsystem.sv */
/*
 * Branch subsystem
 * Register file, operand collector, branch unit and result collector
 */

`timescale 1ns/100ps

module branch_subsystem (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Issue
    input  logic                     issue_valid_i,
    input  bru_pkg::issue_req_t      issue_req_i,
    output logic                     issue_ready_o,
    // Register load
    input  logic                     load_valid_i,
    input  bru_pkg::rf_write_t       load_i,
    output logic                     load_ready_o,
    // Completion
    output logic                     cpl_valid_o,
    output bru_pkg::bru_result_t     cpl_o,
    input  logic                     cpl_ready_i,
    // Redirect pulse, no back-pressure
    output bru_pkg::fetch_redirect_t redirect_o
);

    import bru_pkg::*;

    // Register file reads
    wid_t       rd_wid;
    reg_idx_t   rd0_idx;
    reg_idx_t   rd1_idx;
    warp_data_t rd0_data;
    warp_data_t rd1_data;

    // Collector to branch unit
    logic     req_valid;
    logic     req_ready;
    bru_req_t req;

    // Branch unit to result collector
    logic        res_valid;
    logic        res_ready;
    bru_result_t res;

    // Writeback
    logic      wb_valid;
    rf_write_t wb;

    warp_regfile i_warp_regfile (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .rd_wid_i     ( rd_wid       ),
        .rd0_idx_i    ( rd0_idx      ),
        .rd1_idx_i    ( rd1_idx      ),
        .rd0_data_o   ( rd0_data     ),
        .rd1_data_o   ( rd1_data     ),
        .wb_valid_i   ( wb_valid     ),
        .wb_i         ( wb           ),
        .load_valid_i ( load_valid_i ),
        .load_i       ( load_i       ),
        .load_ready_o ( load_ready_o )
    );

    operand_collector i_operand_collector (
        .clk_i         ( clk_i         ),
        .arst_n_i      ( arst_n_i      ),
        .issue_valid_i ( issue_valid_i ),
        .issue_req_i   ( issue_req_i   ),
        .issue_ready_o ( issue_ready_o ),
        .rd_wid_o      ( rd_wid        ),
        .rd0_idx_o     ( rd0_idx       ),
        .rd1_idx_o     ( rd1_idx       ),
        .rd0_data_i    ( rd0_data      ),
        .rd1_data_i    ( rd1_data      ),
        .req_valid_o   ( req_valid     ),
        .req_o         ( req           ),
        .req_ready_i   ( req_ready     )
    );

    branch_unit i_branch_unit (
        .clk_i       ( clk_i      ),
        .arst_n_i    ( arst_n_i   ),
        .req_valid_i ( req_valid  ),
        .req_i       ( req        ),
        .req_ready_o ( req_ready  ),
        .res_valid_o ( res_valid  ),
        .res_o       ( res        ),
        .res_ready_i ( res_ready  ),
        .redirect_o  ( redirect_o )
    );

    result_collector i_result_collector (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .res_valid_i ( res_valid   ),
        .res_i       ( res         ),
        .res_ready_o ( res_ready   ),
        .cpl_valid_o ( cpl_valid_o ),
        .cpl_o       ( cpl_o       ),
        .cpl_ready_i ( cpl_ready_i ),
        .wb_valid_o  ( wb_valid    ),
        .wb_o        ( wb          )
    );

endmodule

/* source/result_collector.sv */
/*
 * Result collector
 * Forwards branch results as completions and writes the condition back
 */

`timescale 1ns/100ps

module result_collector (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // Result from the branch unit
    input  logic                  res_valid_i,
    input  bru_pkg::bru_result_t  res_i,
    output logic                  res_ready_o,
    // Completion
    output logic                  cpl_valid_o,
    output bru_pkg::bru_result_t  cpl_o,
    input  logic                  cpl_ready_i,
    // Writeback to the register file
    output logic                  wb_valid_o,
    output bru_pkg::rf_write_t    wb_o
);

    import bru_pkg::*;

    logic cpl_fire;

    // ##############################
    // Completion path
    // ##############################

    // Zero latency, the result itself is the completion
    assign cpl_valid_o = res_valid_i;
    assign cpl_o       = res_i;
    assign res_ready_o = cpl_ready_i;

    assign cpl_fire = cpl_valid_o && cpl_ready_i;

    // ##############################
    // Writeback
    // ##############################

    // Same cycle as the completion transfer
    assign wb_valid_o = cpl_fire;

    // Target the issuing warp, inactive lanes untouched
    assign wb_o.wid  = iid_to_wid(res_i.iid);
    assign wb_o.idx  = res_i.dst;
    assign wb_o.mask = res_i.act_mask;
    assign wb_o.data = res_i.data;

    // Every completed branch had at least one active lane at issue
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cpl_fire |-> cpl_o.act_mask != '0)
        else $error("result_collector: completion with empty act mask");

endmodule

/* source/branch_unit.sv */
/*
 * Branch unit
 * Evaluates BNZ/BEZ per lane, registers the fetch redirect, buffers the result
 */

`timescale 1ns/100ps

`include "bru_macros.svh"

module branch_unit (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Collected request
    input  logic                     req_valid_i,
    input  bru_pkg::bru_req_t        req_i,
    output logic                     req_ready_o,
    // Result towards the result collector
    output logic                     res_valid_o,
    output bru_pkg::bru_result_t     res_o,
    input  logic                     res_ready_i,
    // Redirect towards the fetcher
    output bru_pkg::fetch_redirect_t redirect_o
);

    import bru_pkg::*;

    act_mask_t   cond;
    bru_result_t res_d;
    logic        req_fire;

    logic [`BRU_OFFSET_WIDTH-1:0] offset;
    pc_t                          target_pc;

    logic      redirect_valid_q;
    wid_t      redirect_wid_q;
    act_mask_t redirect_mask_q;
    pc_t       redirect_pc_q;

    // ##############################
    // Condition
    // ##############################

    // Per-lane test on operand 1
    always_comb begin
        for (int l = 0; l < `BRU_WARP_WIDTH; l++) begin
            case (req_i.subtype)
                BRU_BNZ: cond[l] = (req_i.op1[l] != '0);
                BRU_BEZ: cond[l] = (req_i.op1[l] == '0);
                default: cond[l] = 1'b0;
            endcase
        end
    end

    // Lane data is the condition as 0 or 1
    always_comb begin
        for (int l = 0; l < `BRU_WARP_WIDTH; l++) begin
            res_d.data[l] = {{(`BRU_REG_WIDTH-1){1'b0}}, cond[l]};
        end
    end

    assign res_d.iid      = req_i.iid;
    assign res_d.dst      = req_i.dst;
    assign res_d.act_mask = req_i.act_mask;

    // ##############################
    // Redirect
    // ##############################

    assign req_fire = req_valid_i && req_ready_o;

    // Offset from operand 0 lane 0, sign-extended to PC width
    assign offset    = req_i.op0[0][`BRU_OFFSET_WIDTH-1:0];
    assign target_pc = req_i.pc
        + {{(`BRU_PC_WIDTH-`BRU_OFFSET_WIDTH){offset[`BRU_OFFSET_WIDTH-1]}}, offset}
        + pc_t'(1);

    // One-cycle pulse per accepted request
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            redirect_valid_q <= 1'b0;
        end else begin
            redirect_valid_q <= req_fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            redirect_wid_q  <= iid_to_wid(req_i.iid);
            redirect_mask_q <= req_i.act_mask & cond;
            redirect_pc_q   <= target_pc;
        end
    end

    assign redirect_o.valid = redirect_valid_q;
    assign redirect_o.wid   = redirect_wid_q;
    assign redirect_o.mask  = redirect_mask_q;
    assign redirect_o.pc    = redirect_pc_q;

    // ##############################
    // Result buffer
    // ##############################

    stream_register #(
        .T ( bru_result_t )
    ) i_res_reg (
        .clk_i    ( clk_i       ),
        .arst_n_i ( arst_n_i    ),
        .valid_i  ( req_valid_i ),
        .ready_o  ( req_ready_o ),
        .data_i   ( res_d       ),
        .valid_o  ( res_valid_o ),
        .ready_i  ( res_ready_i ),
        .data_o   ( res_o       )
    );

    // Collector must only forward decodable branches
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_valid_i |-> req_i.subtype inside {BRU_BNZ, BRU_BEZ})
        else $error("branch_unit: unknown subtype %0h", req_i.subtype);

endmodule

/* source/operand_collector.sv */
/*
 * Operand collector
 * Reads both sources of an issued branch and buffers the collected request
 */

`timescale 1ns/100ps

module operand_collector (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    // Issue from the scheduler
    input  logic                 issue_valid_i,
    input  bru_pkg::issue_req_t  issue_req_i,
    output logic                 issue_ready_o,
    // Register file read
    output bru_pkg::wid_t        rd_wid_o,
    output bru_pkg::reg_idx_t    rd0_idx_o,
    output bru_pkg::reg_idx_t    rd1_idx_o,
    input  bru_pkg::warp_data_t  rd0_data_i,
    input  bru_pkg::warp_data_t  rd1_data_i,
    // Collected request to the branch unit
    output logic                 req_valid_o,
    output bru_pkg::bru_req_t    req_o,
    input  logic                 req_ready_i
);

    import bru_pkg::*;

    bru_req_t req_d;

    // ##############################
    // Operand read
    // ##############################

    // Both reads hit the issuing warp
    assign rd_wid_o  = iid_to_wid(issue_req_i.iid);
    assign rd0_idx_o = issue_req_i.src0;
    assign rd1_idx_o = issue_req_i.src1;

    // Merge issue fields with read data
    assign req_d.iid      = issue_req_i.iid;
    assign req_d.pc       = issue_req_i.pc;
    assign req_d.subtype  = issue_req_i.subtype;
    assign req_d.dst      = issue_req_i.dst;
    assign req_d.act_mask = issue_req_i.act_mask;
    assign req_d.op0      = rd0_data_i;
    assign req_d.op1      = rd1_data_i;

    // ##############################
    // Request buffer
    // ##############################

    // Operands captured on the issue edge
    stream_register #(
        .T ( bru_req_t )
    ) i_req_reg (
        .clk_i    ( clk_i         ),
        .arst_n_i ( arst_n_i      ),
        .valid_i  ( issue_valid_i ),
        .ready_o  ( issue_ready_o ),
        .data_i   ( req_d         ),
        .valid_o  ( req_valid_o   ),
        .ready_i  ( req_ready_i   ),
        .data_o   ( req_o         )
    );

    // Issued work may not vanish while the collector is stalled
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        issue_valid_i && !issue_ready_o |=> issue_valid_i)
        else $error("operand_collector: issue withdrawn before transfer");

endmodule

/* source/warp_regfile.sv */
/*
 * Warp register file
 * Per-warp, per-lane storage, two combinational reads, one lane-masked write
 */

`timescale 1ns/100ps

`include "bru_macros.svh"

module warp_regfile (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    // Read ports, both on the same warp
    input  bru_pkg::wid_t        rd_wid_i,
    input  bru_pkg::reg_idx_t    rd0_idx_i,
    input  bru_pkg::reg_idx_t    rd1_idx_i,
    output bru_pkg::warp_data_t  rd0_data_o,
    output bru_pkg::warp_data_t  rd1_data_o,
    // Writeback from the result collector
    input  logic                 wb_valid_i,
    input  bru_pkg::rf_write_t   wb_i,
    // External load
    input  logic                 load_valid_i,
    input  bru_pkg::rf_write_t   load_i,
    output logic                 load_ready_o
);

    import bru_pkg::*;

    // Warps x registers, lanes packed inside each entry
    warp_data_t mem_q [`BRU_NUM_WARPS][`BRU_NUM_REGS];

    rf_write_t wr;
    logic      wr_en;

    // ##############################
    // Write arbitration
    // ##############################

    // Writeback always wins, load waits
    assign load_ready_o = !wb_valid_i;
    assign wr           = wb_valid_i ? wb_i : load_i;
    assign wr_en        = wb_valid_i || load_valid_i;

    // Storage, cleared to zero on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int w = 0; w < `BRU_NUM_WARPS; w++) begin
                for (int r = 0; r < `BRU_NUM_REGS; r++) begin
                    mem_q[w][r] <= '0;
                end
            end
        end else if (wr_en) begin
            // Only masked lanes change
            for (int l = 0; l < `BRU_WARP_WIDTH; l++) begin
                if (wr.mask[l]) begin
                    mem_q[wr.wid][wr.idx][l] <= wr.data[l];
                end
            end
        end
    end

    // ##############################
    // Reads
    // ##############################

    assign rd0_data_o = mem_q[rd_wid_i][rd0_idx_i];
    assign rd1_data_o = mem_q[rd_wid_i][rd1_idx_i];

    // Writers must name at least one lane
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wr_en |-> wr.mask != '0)
        else $error("warp_regfile: write with empty lane mask");

endmodule

/* source/stream_register.sv */
/*
 * Stream register
 * One-entry valid/ready pipeline stage for any payload type
 */

`timescale 1ns/100ps

module stream_register #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic arst_n_i,
    // Upstream
    input  logic valid_i,
    output logic ready_o,
    input  T     data_i,
    // Downstream
    output logic valid_o,
    input  logic ready_i,
    output T     data_o
);

    logic full_q;
    T     data_q;

    // Accept when empty or when the held item leaves this cycle
    assign ready_o = !full_q || ready_i;

    // Occupancy
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (ready_o) begin
            full_q <= valid_i;
        end
    end

    // Payload, loaded on every upstream transfer
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = full_q;
    assign data_o  = data_q;

    // Stalled item must not change under the consumer
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o))
        else $error("stream_register: payload changed while stalled");

endmodule

/* source/bru_pkg.sv */
/*
 * Branch slice package
 * Subtype encoding and the packed payloads of every stream and write port
 */

`include "bru_macros.svh"

package bru_pkg;

    // Branch kinds handled by the branch unit
    typedef enum logic [1:0] {
        BRU_BNZ = 2'b00,  // taken where the lane is nonzero
        BRU_BEZ = 2'b01   // taken where the lane is zero
    } bru_subtype_e;

    // One register across all lanes, lane 0 in the low bits
    typedef logic [`BRU_WARP_WIDTH-1:0][`BRU_REG_WIDTH-1:0] warp_data_t;
    typedef logic [`BRU_WARP_WIDTH-1:0]                     act_mask_t;
    typedef logic [$clog2(`BRU_NUM_WARPS)-1:0]              wid_t;
    typedef logic [$clog2(`BRU_NUM_REGS)-1:0]               reg_idx_t;
    // Tag above, warp ID in the low bits
    typedef logic [`BRU_TAG_WIDTH+$clog2(`BRU_NUM_WARPS)-1:0] iid_t;
    typedef logic [`BRU_PC_WIDTH-1:0]                       pc_t;

    // Issued branch, sources not yet read
    typedef struct packed {
        iid_t         iid;
        pc_t          pc;
        bru_subtype_e subtype;
        reg_idx_t     dst;
        reg_idx_t     src0;
        reg_idx_t     src1;
        act_mask_t    act_mask;
    } issue_req_t;

    // Branch with both operands collected
    typedef struct packed {
        iid_t         iid;
        pc_t          pc;
        bru_subtype_e subtype;
        reg_idx_t     dst;
        act_mask_t    act_mask;
        warp_data_t   op0;
        warp_data_t   op1;
    } bru_req_t;

    // Executed branch, data is 1 or 0 per lane
    typedef struct packed {
        iid_t       iid;
        reg_idx_t   dst;
        act_mask_t  act_mask;
        warp_data_t data;
    } bru_result_t;

    // Redirect towards the fetcher
    typedef struct packed {
        logic      valid;
        wid_t      wid;
        act_mask_t mask;
        pc_t       pc;
    } fetch_redirect_t;

    // Lane-masked register write
    typedef struct packed {
        wid_t       wid;
        reg_idx_t   idx;
        act_mask_t  mask;
        warp_data_t data;
    } rf_write_t;

    // Warp ID lives in the low bits of the iid
    function automatic wid_t iid_to_wid(iid_t iid);
        return iid[$bits(wid_t)-1:0];
    endfunction

endpackage

/* include/bru_macros.svh */
/*
 * Branch slice sizes
 * Warp, lane, register and PC dimensions shared by the package and the RTL
 */

`ifndef BRU_MACROS_SVH
`define BRU_MACROS_SVH

// Warps held by the compute unit
`define BRU_NUM_WARPS 4

// Lanes (threads) per warp
`define BRU_WARP_WIDTH 4

// Bits in one lane register
`define BRU_REG_WIDTH 32

// Architectural registers per warp
`define BRU_NUM_REGS 16

// Program counter bits
`define BRU_PC_WIDTH 16

// In-flight tag bits per warp, sits above the warp ID in an iid
`define BRU_TAG_WIDTH 3

// Branch offset bits, taken from operand 0 lane 0
`define BRU_OFFSET_WIDTH 8

`endif
